// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_mmu_top -o sim_tb_mmu_top
sim_out=$(./obj_dir/sim_tb_mmu_top)
echo "$sim_out"

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: source/addr_xlate.sv
`timescale 1ns/100ps

module addr_xlate #(
    parameter bit has_store = 1'b0
) (
    input  mmu_pkg::vaddr_t     vaddr,
    input  logic                store,    // only looked at on the data side
    input  mmu_pkg::asid_t      asid,
    tlb_lookup_if.requester     lk,
    output mmu_pkg::paddr_t     paddr,
    output mmu_pkg::cattr_t     cattr,
    output mmu_pkg::xlate_exc_t exc
);
    import mmu_pkg::*;

    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;
    localparam cattr_t     C_KSEG0   = 3'd3;    // cacheable
    localparam cattr_t     C_KSEG1   = 3'd2;    // uncached

    logic kseg0;
    logic kseg1;
    logic is_store;

    assign kseg0    = (vaddr[31:29] == SEG_KSEG0);
    assign kseg1    = (vaddr[31:29] == SEG_KSEG1);
    assign is_store = has_store && store;

    // tlb is searched every cycle, result ignored when unmapped
    assign lk.vpn2     = vaddr[31:13];
    assign lk.odd_page = vaddr[12];
    assign lk.asid     = asid;

    always_comb begin
        if (kseg0 || kseg1) begin
            paddr = {3'b000, vaddr[28:0]};
            cattr = kseg0 ? C_KSEG0 : C_KSEG1;
            exc   = XC_NONE;
        end else begin
            paddr = {lk.pfn, vaddr[11:0]};
            cattr = lk.c;
            if (!lk.found)
                exc = XC_REFILL;
            else if (!lk.v)
                exc = XC_INVALID;
            else if (is_store && !lk.d)
                exc = XC_MODIFIED;    // first store to a clean page
            else
                exc = XC_NONE;
        end
    end

endmodule

// File: source/mmu_config.svh
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// tlb geometry
`define TLB_NUM         16

// axi4-lite maintenance port
`define AXIL_ADDR_W     5
`define AXIL_DATA_W     32

// register byte offsets
`define REG_INDEX       5'h00
`define REG_ENTRYHI     5'h04
`define REG_ENTRYLO0    5'h08
`define REG_ENTRYLO1    5'h0C
`define REG_CMD         5'h10

`endif

// File: source/mmu_pkg.sv
`include "mmu_config.svh"

package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;     // vaddr[31:13], one even/odd page pair
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [$clog2(`TLB_NUM)-1:0] tlb_idx_t;

    typedef enum logic [1:0] {
        XC_NONE     = 2'd0,
        XC_REFILL   = 2'd1,
        XC_INVALID  = 2'd2,
        XC_MODIFIED = 2'd3
    } xlate_exc_t;

    // encoding matches the low bits written to the cmd register
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_TLBWI = 2'd1,
        CMD_TLBR  = 2'd2,
        CMD_TLBP  = 2'd3
    } tlb_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_RESP = 2'd2
    } maint_state_t;

endpackage

// File: source/mmu_top.sv
`timescale 1ns/100ps
`include "mmu_config.svh"

module mmu_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`AXIL_ADDR_W-1:0]   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXIL_DATA_W-1:0]   wdata,
    input  logic [`AXIL_DATA_W/8-1:0] wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  mmu_pkg::vaddr_t           if_vaddr,
    output mmu_pkg::paddr_t           if_paddr,
    output mmu_pkg::cattr_t           if_cattr,
    output mmu_pkg::xlate_exc_t       if_exc,
    input  mmu_pkg::vaddr_t           d_vaddr,
    input  logic                      d_store,
    output mmu_pkg::paddr_t           d_paddr,
    output mmu_pkg::cattr_t           d_cattr,
    output mmu_pkg::xlate_exc_t       d_exc,
    output logic                      data_stall
);
    import mmu_pkg::*;

    asid_t cur_asid;    // from entryhi

    tlb_lookup_if fetch_lk ();
    tlb_lookup_if data_lk ();
    tlb_lookup_if s1_lk ();
    tlb_maint_if  maint_bus ();

    tlb #(
        .NUM(`TLB_NUM)
    ) u_tlb (
        .clk   (clk),
        .s0    (fetch_lk),
        .s1    (s1_lk),
        .maint (maint_bus)
    );

    addr_xlate #(
        .has_store(1'b0)
    ) u_fetch_xlate (
        .vaddr (if_vaddr),
        .store (1'b0),
        .asid  (cur_asid),
        .lk    (fetch_lk),
        .paddr (if_paddr),
        .cattr (if_cattr),
        .exc   (if_exc)
    );

    // data query reaches port 1 through the maintenance block
    addr_xlate #(
        .has_store(1'b1)
    ) u_data_xlate (
        .vaddr (d_vaddr),
        .store (d_store),
        .asid  (cur_asid),
        .lk    (data_lk),
        .paddr (d_paddr),
        .cattr (d_cattr),
        .exc   (d_exc)
    );

    tlb_maint_regs u_maint (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .data_q     (data_lk),
        .s1         (s1_lk),
        .maint      (maint_bus),
        .cur_asid   (cur_asid),
        .data_stall (data_stall)
    );

endmodule

// File: source/tlb.sv
`timescale 1ns/100ps
`include "mmu_config.svh"

module tlb #(
    parameter int NUM = `TLB_NUM
) (
    input  logic       clk,
    tlb_lookup_if.tlb  s0,     // fetch side
    tlb_lookup_if.tlb  s1,     // data side, shared with tlbp
    tlb_maint_if.tlb   maint
);
    import mmu_pkg::*;

    // entry storage, second index picks even (0) or odd (1) page
    vpn2_t  tlb_vpn2 [NUM];
    asid_t  tlb_asid [NUM];
    logic   tlb_g    [NUM];
    pfn_t   tlb_pfn  [NUM][2];
    cattr_t tlb_c    [NUM][2];
    logic   tlb_d    [NUM][2];
    logic   tlb_v    [NUM][2];

    logic [NUM-1:0] match0;
    logic [NUM-1:0] match1;
    tlb_idx_t       hit0;
    tlb_idx_t       hit1;

    // lowest matching entry wins
    function automatic tlb_idx_t first_hit(input logic [NUM-1:0] m);
        tlb_idx_t idx;
        idx = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (m[i])
                idx = tlb_idx_t'(i);
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (maint.we) begin
            tlb_vpn2[maint.w_index]   <= maint.w_vpn2;
            tlb_asid[maint.w_index]   <= maint.w_asid;
            tlb_g[maint.w_index]      <= maint.w_g;
            tlb_pfn[maint.w_index][0] <= maint.w_pfn0;
            tlb_c[maint.w_index][0]   <= maint.w_c0;
            tlb_d[maint.w_index][0]   <= maint.w_d0;
            tlb_v[maint.w_index][0]   <= maint.w_v0;
            tlb_pfn[maint.w_index][1] <= maint.w_pfn1;
            tlb_c[maint.w_index][1]   <= maint.w_c1;
            tlb_d[maint.w_index][1]   <= maint.w_d1;
            tlb_v[maint.w_index][1]   <= maint.w_v1;
        end
    end

    // indexed read for tlbr
    assign maint.r_vpn2 = tlb_vpn2[maint.r_index];
    assign maint.r_asid = tlb_asid[maint.r_index];
    assign maint.r_g    = tlb_g[maint.r_index];
    assign maint.r_pfn0 = tlb_pfn[maint.r_index][0];
    assign maint.r_c0   = tlb_c[maint.r_index][0];
    assign maint.r_d0   = tlb_d[maint.r_index][0];
    assign maint.r_v0   = tlb_v[maint.r_index][0];
    assign maint.r_pfn1 = tlb_pfn[maint.r_index][1];
    assign maint.r_c1   = tlb_c[maint.r_index][1];
    assign maint.r_d1   = tlb_d[maint.r_index][1];
    assign maint.r_v1   = tlb_v[maint.r_index][1];

    for (genvar i = 0; i < NUM; i++) begin : g_match
        assign match0[i] = (s0.vpn2 == tlb_vpn2[i]) && ((s0.asid == tlb_asid[i]) || tlb_g[i]);
        assign match1[i] = (s1.vpn2 == tlb_vpn2[i]) && ((s1.asid == tlb_asid[i]) || tlb_g[i]);
    end

    assign hit0 = first_hit(match0);
    assign hit1 = first_hit(match1);

    // miss forces every result field to zero
    assign s0.found = |match0;
    assign s0.index = s0.found ? hit0 : '0;
    assign s0.pfn   = s0.found ? tlb_pfn[hit0][s0.odd_page] : '0;
    assign s0.c     = s0.found ? tlb_c[hit0][s0.odd_page] : '0;
    assign s0.d     = s0.found & tlb_d[hit0][s0.odd_page];
    assign s0.v     = s0.found & tlb_v[hit0][s0.odd_page];

    assign s1.found = |match1;
    assign s1.index = s1.found ? hit1 : '0;
    assign s1.pfn   = s1.found ? tlb_pfn[hit1][s1.odd_page] : '0;
    assign s1.c     = s1.found ? tlb_c[hit1][s1.odd_page] : '0;
    assign s1.d     = s1.found & tlb_d[hit1][s1.odd_page];
    assign s1.v     = s1.found & tlb_v[hit1][s1.odd_page];

endmodule

// File: source/tlb_if.sv
`timescale 1ns/100ps

interface tlb_lookup_if;
    import mmu_pkg::*;

    vpn2_t    vpn2;
    logic     odd_page;
    asid_t    asid;
    logic     found;
    tlb_idx_t index;
    pfn_t     pfn;
    cattr_t   c;
    logic     d;
    logic     v;

    modport requester (output vpn2, odd_page, asid, input found, index, pfn, c, d, v);
    modport tlb (input vpn2, odd_page, asid, output found, index, pfn, c, d, v);
endinterface

interface tlb_maint_if;
    import mmu_pkg::*;

    logic     we;
    tlb_idx_t w_index;
    vpn2_t    w_vpn2;
    asid_t    w_asid;
    logic     w_g;
    pfn_t     w_pfn0;
    cattr_t   w_c0;
    logic     w_d0;
    logic     w_v0;
    pfn_t     w_pfn1;
    cattr_t   w_c1;
    logic     w_d1;
    logic     w_v1;

    tlb_idx_t r_index;
    vpn2_t    r_vpn2;
    asid_t    r_asid;
    logic     r_g;
    pfn_t     r_pfn0;
    cattr_t   r_c0;
    logic     r_d0;
    logic     r_v0;
    pfn_t     r_pfn1;
    cattr_t   r_c1;
    logic     r_d1;
    logic     r_v1;

    modport maint (
        output we, w_index, w_vpn2, w_asid, w_g,
        output w_pfn0, w_c0, w_d0, w_v0, w_pfn1, w_c1, w_d1, w_v1,
        output r_index,
        input  r_vpn2, r_asid, r_g, r_pfn0, r_c0, r_d0, r_v0, r_pfn1, r_c1, r_d1, r_v1
    );
    modport tlb (
        input  we, w_index, w_vpn2, w_asid, w_g,
        input  w_pfn0, w_c0, w_d0, w_v0, w_pfn1, w_c1, w_d1, w_v1,
        input  r_index,
        output r_vpn2, r_asid, r_g, r_pfn0, r_c0, r_d0, r_v0, r_pfn1, r_c1, r_d1, r_v1
    );
endinterface

// File: source/tlb_maint_regs.sv
`timescale 1ns/100ps
`include "mmu_config.svh"

module tlb_maint_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`AXIL_ADDR_W-1:0]   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXIL_DATA_W-1:0]   wdata,
    input  logic [`AXIL_DATA_W/8-1:0] wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    tlb_lookup_if.tlb                 data_q,
    tlb_lookup_if.requester           s1,
    tlb_maint_if.maint                maint,
    output mmu_pkg::asid_t            cur_asid,
    output logic                      data_stall
);
    import mmu_pkg::*;

    localparam int DW = `AXIL_DATA_W;
    localparam int IW = $bits(tlb_idx_t);
    // writable bits of each register
    localparam logic [DW-1:0] IDX_MASK = {1'b1, {(DW-1-IW){1'b0}}, {IW{1'b1}}};
    localparam logic [DW-1:0] HI_MASK  = 32'hffff_e0ff;
    localparam logic [DW-1:0] LO_MASK  = 32'h03ff_ffff;

    maint_state_t  state;
    tlb_cmd_t      cmd_q;
    tlb_cmd_t      wr_cmd;
    logic [DW-1:0] index_q;
    logic [DW-1:0] entryhi_q;
    logic [DW-1:0] entrylo0_q;
    logic [DW-1:0] entrylo1_q;
    logic [DW-1:0] rd_mux;
    logic          wr_hs;
    logic          rd_hs;
    logic          cmd_wr;
    logic          probe;
    tlb_idx_t      idx_f;
    vpn2_t         hi_vpn2;

    function automatic logic [DW-1:0] merge_strb(input logic [DW-1:0]   old_v,
                                                 input logic [DW-1:0]   new_v,
                                                 input logic [DW/8-1:0] strb);
        logic [DW-1:0] res;
        res = old_v;
        for (int b = 0; b < DW / 8; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    // write channel, aw and w taken together
    assign wr_hs   = awvalid && wvalid && (state == ST_IDLE);
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign bvalid  = (state == ST_RESP);
    assign bresp   = 2'b00;
    assign wr_cmd  = tlb_cmd_t'(wdata[1:0]);
    assign cmd_wr  = wr_hs && (awaddr == `REG_CMD) && wstrb[0] && (wr_cmd != CMD_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cmd_q <= CMD_NONE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_wr) begin
                        cmd_q <= wr_cmd;
                        state <= ST_EXEC;
                    end else if (wr_hs) begin
                        state <= ST_RESP;    // plain register write
                    end
                end
                ST_EXEC: state <= ST_RESP;
                ST_RESP: begin
                    if (bready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q    <= '0;
            entryhi_q  <= '0;
            entrylo0_q <= '0;
            entrylo1_q <= '0;
        end else if (wr_hs) begin
            case (awaddr)
                `REG_INDEX:    index_q    <= merge_strb(index_q, wdata, wstrb) & IDX_MASK;
                `REG_ENTRYHI:  entryhi_q  <= merge_strb(entryhi_q, wdata, wstrb) & HI_MASK;
                `REG_ENTRYLO0: entrylo0_q <= merge_strb(entrylo0_q, wdata, wstrb) & LO_MASK;
                `REG_ENTRYLO1: entrylo1_q <= merge_strb(entrylo1_q, wdata, wstrb) & LO_MASK;
                default: ;
            endcase
        end else if (state == ST_EXEC) begin
            case (cmd_q)
                CMD_TLBR: begin
                    entryhi_q  <= {maint.r_vpn2, 5'b0, maint.r_asid};
                    entrylo0_q <= {6'b0, maint.r_pfn0, maint.r_c0,
                                   maint.r_d0, maint.r_v0, maint.r_g};
                    entrylo1_q <= {6'b0, maint.r_pfn1, maint.r_c1,
                                   maint.r_d1, maint.r_v1, maint.r_g};
                end
                CMD_TLBP: begin
                    if (s1.found)
                        index_q <= {1'b0, {(DW-1-IW){1'b0}}, s1.index};
                    else
                        index_q[DW-1] <= 1'b1;    // P, index left as is
                end
                default: ;
            endcase
        end
    end

    // read channel, arready one cycle after arvalid
    assign rd_hs = arvalid && arready;
    assign rresp = 2'b00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_comb begin
        case (araddr)
            `REG_INDEX:    rd_mux = index_q;
            `REG_ENTRYHI:  rd_mux = entryhi_q;
            `REG_ENTRYLO0: rd_mux = entrylo0_q;
            `REG_ENTRYLO1: rd_mux = entrylo1_q;
            default:       rd_mux = '0;    // cmd and holes
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_hs)
            rdata <= rd_mux;
    end

    assign idx_f    = index_q[IW-1:0];
    assign hi_vpn2  = entryhi_q[31:13];
    assign cur_asid = entryhi_q[7:0];

    // tlbp steals search port 1 for its exec cycle
    assign probe      = (state == ST_EXEC) && (cmd_q == CMD_TLBP);
    assign data_stall = probe;

    assign s1.vpn2     = probe ? hi_vpn2 : data_q.vpn2;
    assign s1.odd_page = probe ? 1'b0 : data_q.odd_page;
    assign s1.asid     = probe ? cur_asid : data_q.asid;

    assign data_q.found = s1.found;
    assign data_q.index = s1.index;
    assign data_q.pfn   = s1.pfn;
    assign data_q.c     = s1.c;
    assign data_q.d     = s1.d;
    assign data_q.v     = s1.v;

    assign maint.we      = (state == ST_EXEC) && (cmd_q == CMD_TLBWI);
    assign maint.w_index = idx_f;
    assign maint.w_vpn2  = hi_vpn2;
    assign maint.w_asid  = cur_asid;
    assign maint.w_g     = entrylo0_q[0] & entrylo1_q[0];
    assign maint.w_pfn0  = entrylo0_q[25:6];
    assign maint.w_c0    = entrylo0_q[5:3];
    assign maint.w_d0    = entrylo0_q[2];
    assign maint.w_v0    = entrylo0_q[1];
    assign maint.w_pfn1  = entrylo1_q[25:6];
    assign maint.w_c1    = entrylo1_q[5:3];
    assign maint.w_d1    = entrylo1_q[2];
    assign maint.w_v1    = entrylo1_q[1];
    assign maint.r_index = idx_f;

endmodule

// File: src.f
+incdir+source
source/mmu_pkg.sv
source/tlb_if.sv
source/tlb.sv
source/addr_xlate.sv
source/tlb_maint_regs.sv
source/mmu_top.sv
verification/tb_mmu_top.sv

// File: verification/tb_mmu_top.sv
`timescale 1ns/100ps
`include "mmu_config.svh"

module tb_mmu_top;
    import mmu_pkg::*;

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] SEED           = 32'h7c15d184;

    logic                      clk;
    logic                      rst_n;
    logic [`AXIL_ADDR_W-1:0]   awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_DATA_W/8-1:0] wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [`AXIL_ADDR_W-1:0]   araddr;
    logic                      arvalid;
    logic                      arready;
    logic [`AXIL_DATA_W-1:0]   rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;
    vaddr_t                    if_vaddr;
    paddr_t                    if_paddr;
    cattr_t                    if_cattr;
    xlate_exc_t                if_exc;
    vaddr_t                    d_vaddr;
    logic                      d_store;
    paddr_t                    d_paddr;
    cattr_t                    d_cattr;
    xlate_exc_t                d_exc;
    logic                      data_stall;

    int    errors;
    int    checks;
    int    tests;
    int    t_errs;
    int    t_checks;
    int    stall_cycles;    // stall cycles seen during the last write
    int    cycle_cnt;
    string test_name;

    // reference model of the registers and entries
    logic [31:0] m_index;
    logic [31:0] m_hi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    vpn2_t       m_vpn2 [`TLB_NUM];
    asid_t       m_asid [`TLB_NUM];
    logic        m_g    [`TLB_NUM];
    pfn_t        m_pfn  [`TLB_NUM][2];
    cattr_t      m_c    [`TLB_NUM][2];
    logic        m_d    [`TLB_NUM][2];
    logic        m_v    [`TLB_NUM][2];
    vpn2_t       rnd_vpn2 [`TLB_NUM];

    mmu_top UUT (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .if_vaddr(if_vaddr), .if_paddr(if_paddr), .if_cattr(if_cattr), .if_exc(if_exc),
        .d_vaddr(d_vaddr), .d_store(d_store), .d_paddr(d_paddr), .d_cattr(d_cattr),
        .d_exc(d_exc), .data_stall(data_stall)
    );

    always #2 clk = ~clk;

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        t_checks++;
        assert (act === exp) else begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
            t_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        t_errs    = 0;
        t_checks  = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s finished: %0d checks, %0d errors", test_name, t_checks, t_errs);
    endtask

    function automatic logic [31:0] make_lo(input pfn_t pfn, input cattr_t c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic model_lookup(input vpn2_t vpn2, input asid_t asid,
                                output logic found, output tlb_idx_t hit);
        found = 1'b0;
        hit   = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (!found && m_vpn2[i] == vpn2 && (m_asid[i] == asid || m_g[i])) begin
                found = 1'b1;
                hit   = tlb_idx_t'(i);
            end
        end
    endtask

    task automatic model_xlate(input logic [31:0] va, input logic st, output logic [31:0] pa,
                               output cattr_t ca, output logic [1:0] ex);
        logic     found;
        tlb_idx_t i;
        logic     pg;
        pg = va[12];
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin    // kseg0 or kseg1
            pa = {3'b000, va[28:0]};
            ca = (va[31:29] == 3'b100) ? 3'd3 : 3'd2;
            ex = XC_NONE;
        end else begin
            model_lookup(va[31:13], m_hi[7:0], found, i);
            if (!found) begin
                pa = {20'b0, va[11:0]};
                ca = '0;
                ex = XC_REFILL;
            end else begin
                pa = {m_pfn[i][pg], va[11:0]};
                ca = m_c[i][pg];
                if (!m_v[i][pg])
                    ex = XC_INVALID;
                else if (st && !m_d[i][pg])
                    ex = XC_MODIFIED;
                else
                    ex = XC_NONE;
            end
        end
    endtask

    task automatic model_write(input logic [`AXIL_ADDR_W-1:0] addr, input logic [31:0] data);
        tlb_idx_t i;
        tlb_idx_t hit;
        logic     found;
        i = m_index[$bits(tlb_idx_t)-1:0];
        case (addr)
            `REG_INDEX:    m_index = data & 32'h8000_000f;
            `REG_ENTRYHI:  m_hi    = data & 32'hffff_e0ff;
            `REG_ENTRYLO0: m_lo0   = data & 32'h03ff_ffff;
            `REG_ENTRYLO1: m_lo1   = data & 32'h03ff_ffff;
            `REG_CMD: begin
                if (data[1:0] == CMD_TLBWI) begin
                    m_vpn2[i]   = m_hi[31:13];
                    m_asid[i]   = m_hi[7:0];
                    m_g[i]      = m_lo0[0] & m_lo1[0];
                    m_pfn[i][0] = m_lo0[25:6];
                    m_c[i][0]   = m_lo0[5:3];
                    m_d[i][0]   = m_lo0[2];
                    m_v[i][0]   = m_lo0[1];
                    m_pfn[i][1] = m_lo1[25:6];
                    m_c[i][1]   = m_lo1[5:3];
                    m_d[i][1]   = m_lo1[2];
                    m_v[i][1]   = m_lo1[1];
                end else if (data[1:0] == CMD_TLBR) begin
                    m_hi  = {m_vpn2[i], 5'b0, m_asid[i]};
                    m_lo0 = make_lo(m_pfn[i][0], m_c[i][0], m_d[i][0], m_v[i][0], m_g[i]);
                    m_lo1 = make_lo(m_pfn[i][1], m_c[i][1], m_d[i][1], m_v[i][1], m_g[i]);
                end else if (data[1:0] == CMD_TLBP) begin
                    model_lookup(m_hi[31:13], m_hi[7:0], found, hit);
                    if (found)
                        m_index = 32'(hit);
                    else
                        m_index[31] = 1'b1;    // P on a miss
                end
            end
            default: ;
        endcase
    endtask

    task automatic axi_write(input logic [`AXIL_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= '1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready))
            @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        stall_cycles = 0;
        @(negedge clk);
        while (!bvalid) begin
            if (data_stall)
                stall_cycles++;
            @(negedge clk);
        end
        check_val("bresp", 32'h0, 32'(bresp));
        @(posedge clk);
        bready <= 1'b0;
        model_write(addr, data);
    endtask

    task automatic read_check(input logic [`AXIL_ADDR_W-1:0] addr, input string what,
                              input logic [31:0] exp, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        @(negedge clk);
        while (!rvalid)
            @(negedge clk);
        data = rdata;
        check_val("rresp", 32'h0, 32'(rresp));
        check_val(what, exp, data);
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic write_entry(input int idx, input vpn2_t vpn2, input asid_t asid,
                               input logic [31:0] lo0, input logic [31:0] lo1);
        axi_write(`REG_INDEX, 32'(idx));
        axi_write(`REG_ENTRYHI, {vpn2, 5'b0, asid});
        axi_write(`REG_ENTRYLO0, lo0);
        axi_write(`REG_ENTRYLO1, lo1);
        axi_write(`REG_CMD, 32'(CMD_TLBWI));
    endtask

    // both ports driven in the same cycle and sampled mid-cycle
    task automatic check_xlate(input logic [31:0] ia, input logic [31:0] da, input logic st);
        logic [31:0] pa;
        cattr_t      ca;
        logic [1:0]  ex;
        @(posedge clk);
        if_vaddr <= ia;
        d_vaddr  <= da;
        d_store  <= st;
        @(negedge clk);
        model_xlate(ia, 1'b0, pa, ca, ex);
        check_val("if_paddr", pa, if_paddr);
        check_val("if_cattr", 32'(ca), 32'(if_cattr));
        check_val("if_exc", 32'(ex), 32'(if_exc));
        model_xlate(da, st, pa, ca, ex);
        check_val("d_paddr", pa, d_paddr);
        check_val("d_cattr", 32'(ca), 32'(d_cattr));
        check_val("d_exc", 32'(ex), 32'(d_exc));
    endtask

    function automatic logic [31:0] pick_addr();
        logic [31:0] r;
        r = $urandom;
        if (r[1:0] != 2'b00)    // mostly aim at a loaded entry
            r = {rnd_vpn2[$urandom_range(`TLB_NUM - 1, 0)], 13'($urandom)};
        return r;
    endfunction

    initial begin
        logic [31:0] rd;
        vpn2_t       v;
        logic        dup;

        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        tests  = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        if_vaddr = '0;
        d_vaddr = '0;
        d_store = 1'b0;
        m_index = '0;
        m_hi = '0;
        m_lo0 = '0;
        m_lo1 = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset_unmapped");
        @(negedge clk);
        check_val("awready", 32'h0, 32'(awready));
        check_val("wready", 32'h0, 32'(wready));
        check_val("bvalid", 32'h0, 32'(bvalid));
        check_val("arready", 32'h0, 32'(arready));
        check_val("rvalid", 32'h0, 32'(rvalid));
        check_val("data_stall", 32'h0, 32'(data_stall));
        read_check(`REG_INDEX, "index", 32'h0, rd);
        read_check(`REG_ENTRYHI, "entryhi", 32'h0, rd);
        read_check(`REG_ENTRYLO0, "entrylo0", 32'h0, rd);
        read_check(`REG_ENTRYLO1, "entrylo1", 32'h0, rd);
        read_check(5'h14, "hole", 32'h0, rd);
        check_xlate(32'h8012_3456, 32'ha0ab_cdef, 1'b0);
        check_xlate(32'ha765_4321, 32'h9fff_f000, 1'b1);
        end_test();

        begin_test("write_read");
        // park every entry in kseg0 space so no stale entry can hit
        for (int i = 0; i < `TLB_NUM; i++)
            write_entry(i, {3'b100, 16'(i)}, 8'h00, 32'h0, 32'h0);
        write_entry(5, 19'h01234, 8'h2a, make_lo(20'habcde, 3'd3, 1'b1, 1'b1, 1'b1),
                    make_lo(20'h12345, 3'd2, 1'b0, 1'b1, 1'b0));
        check_val("stall tlbwi", 32'h0, 32'(stall_cycles));
        axi_write(`REG_ENTRYHI, 32'h0);
        axi_write(`REG_ENTRYLO0, 32'h0);
        axi_write(`REG_ENTRYLO1, 32'h0);
        axi_write(`REG_CMD, 32'(CMD_TLBR));
        check_val("stall tlbr", 32'h0, 32'(stall_cycles));
        read_check(`REG_INDEX, "index", 32'h5, rd);
        read_check(`REG_ENTRYHI, "entryhi", {19'h01234, 5'b0, 8'h2a}, rd);
        read_check(`REG_ENTRYLO0, "entrylo0", make_lo(20'habcde, 3'd3, 1'b1, 1'b1, 1'b0), rd);
        read_check(`REG_ENTRYLO1, "entrylo1", make_lo(20'h12345, 3'd2, 1'b0, 1'b1, 1'b0), rd);
        end_test();

        begin_test("mapped");
        write_entry(9, 19'h30f0f, 8'h77, make_lo(20'h00909, 3'd3, 1'b1, 1'b1, 1'b1),
                    make_lo(20'h01919, 3'd3, 1'b1, 1'b1, 1'b1));
        axi_write(`REG_ENTRYHI, {19'h0, 5'b0, 8'h2a});
        check_xlate({19'h01234, 1'b0, 12'h678}, {19'h01234, 1'b1, 12'h9ab}, 1'b0);
        check_xlate({19'h01234, 1'b1, 12'h001}, {19'h01234, 1'b0, 12'hfff}, 1'b1);
        check_xlate({19'h30f0f, 1'b1, 12'h004}, {19'h30f0f, 1'b0, 12'hffc}, 1'b1);
        axi_write(`REG_ENTRYHI, {19'h0, 5'b0, 8'h11});    // asid mismatch
        check_xlate({19'h01234, 1'b0, 12'h678}, {19'h01234, 1'b1, 12'h9ab}, 1'b0);
        check_xlate({19'h30f0f, 1'b0, 12'h123}, {19'h30f0f, 1'b1, 12'h456}, 1'b0);
        end_test();

        begin_test("invalid_modified");
        write_entry(12, 19'h25555, 8'h11, make_lo(20'h50000, 3'd2, 1'b1, 1'b0, 1'b0),
                    make_lo(20'h51111, 3'd3, 1'b0, 1'b1, 1'b0));
        check_xlate({19'h25555, 1'b0, 12'h010}, {19'h25555, 1'b0, 12'h020}, 1'b0);
        check_xlate({19'h25555, 1'b1, 12'h030}, {19'h25555, 1'b1, 12'h040}, 1'b1);
        check_xlate({19'h25555, 1'b1, 12'h050}, {19'h25555, 1'b1, 12'h060}, 1'b0);
        end_test();

        begin_test("probe");
        axi_write(`REG_ENTRYHI, {19'h71111, 5'b0, 8'h42});
        axi_write(`REG_CMD, 32'(CMD_TLBP));
        check_val("stall tlbp miss", 32'h1, 32'(stall_cycles));
        read_check(`REG_INDEX, "index miss", m_index, rd);
        check_val("index P", 32'h1, 32'(rd[31]));
        axi_write(`REG_ENTRYHI, {19'h30f0f, 5'b0, 8'h42});
        axi_write(`REG_CMD, 32'(CMD_TLBP));    // hit clears P left by the miss
        check_val("stall tlbp hit", 32'h1, 32'(stall_cycles));
        read_check(`REG_INDEX, "index hit", 32'h9, rd);
        end_test();

        begin_test("random");
        for (int i = 0; i < `TLB_NUM; i++) begin
            do begin
                v = 19'($urandom);
                if (v[18:17] == 2'b10)
                    v[17] = 1'b1;    // keep out of kseg0/kseg1
                dup = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (rnd_vpn2[j] == v)
                        dup = 1'b1;
                end
            end while (dup);
            rnd_vpn2[i] = v;
            write_entry(i, v, {6'b0, 2'($urandom)}, $urandom & 32'h03ff_ffff,
                        $urandom & 32'h03ff_ffff);
        end
        for (int ph = 0; ph < 2; ph++) begin
            axi_write(`REG_ENTRYHI, {19'h0, 5'b0, 6'b0, 2'($urandom)});
            repeat (60)
                check_xlate(pick_addr(), pick_addr(), 1'($urandom));
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
